/* rv_pkg.sv */
package rv_pkg;

	localparam int XLEN = 32;	// data and address width

	// major opcodes, insn[6:0]
	typedef enum logic [6:0] {
		LOAD   = 7'd3,
		OP_IMM = 7'd19,
		AUIPC  = 7'd23,
		STORE  = 7'd35,
		OP     = 7'd51,
		LUI    = 7'd55,
		BRANCH = 7'd99,
		JALR   = 7'd103,
		JAL    = 7'd111
	} opcode_e;

	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		SLT    = 4'd2,
		SLTU   = 4'd3,
		XOR    = 4'd4,
		OR     = 4'd5,
		AND    = 4'd6,
		SLL    = 4'd7,
		SRL    = 4'd8,
		SRA    = 4'd9,
		PASSB  = 4'd10,	// lui, operand b straight through
		MUL    = 4'd11,
		MULH   = 4'd12,
		MULHSU = 4'd13,
		MULHU  = 4'd14
	} alu_op_e;

	typedef enum logic [2:0] {IMM_I = 3'd0, IMM_S = 3'd1, IMM_B = 3'd2, IMM_J = 3'd3, IMM_U = 3'd4} imm_sel_e;

	typedef enum logic [1:0] {WB_PC4 = 2'd0, WB_ALU = 2'd1, WB_LOAD = 2'd2} wb_sel_e;

	typedef enum logic [2:0] {LD_B = 3'd0, LD_H = 3'd1, LD_W = 3'd2, LD_BU = 3'd3, LD_HU = 3'd4} ld_sel_e;

endpackage

/* ctrl_if.sv */
`timescale 1ns/10ps

interface ctrl_if;
	import rv_pkg::*;

	imm_sel_e   imm_sel;	// immediate format
	alu_op_e    alu_op;
	logic       opa_sel;	// 1: pc, 0: rs1
	logic       opb_sel;	// 1: imm, 0: rs2
	logic       br_un;		// 1: signed compare
	logic       mem_wren;	// store strobe
	logic [2:0] bmask;		// {sw, sh, sb}
	ld_sel_e    ld_sel;		// load size and extension
	logic       rd_wren;	// register write strobe
	wb_sel_e    wb_sel;		// writeback source

	modport dec (
		output imm_sel, alu_op, opa_sel, opb_sel, br_un,
		output mem_wren, bmask, ld_sel, rd_wren, wb_sel
	);

	modport imm (input imm_sel);

	modport exe (input alu_op, opa_sel, opb_sel, br_un);

	modport lsu (input mem_wren, bmask, ld_sel, wb_sel);

	modport rf (input rd_wren);

endinterface

/* control_unit.sv */
`timescale 1ns/10ps

module control_unit #(
	parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic [rv_pkg::XLEN-1:0] i_insn,
	input  logic                    i_br_less,
	input  logic                    i_br_equal,
	input  logic [rv_pkg::XLEN-1:0] i_alu_res,
	output logic [rv_pkg::XLEN-1:0] o_pc,
	output logic                    o_insn_vld,
	ctrl_if.dec                     o_ctrl
);
	import rv_pkg::*;

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic            f7_30;		// sub / sra select
	logic            f7_25;		// M extension
	logic            vld;
	logic            rd_wr;		// before validity and reset gating
	logic            mem_wr;
	logic            pc_sel;	// 1: take alu result as next pc
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_next;

	assign opcode = opcode_e'(i_insn[6:0]);
	assign funct3 = i_insn[14:12];
	assign f7_30  = i_insn[30];
	assign f7_25  = i_insn[25];

	always_comb begin
		vld            = 1'b0;
		rd_wr          = 1'b0;
		mem_wr         = 1'b0;
		pc_sel         = 1'b0;
		o_ctrl.imm_sel = IMM_I;
		o_ctrl.alu_op  = ADD;	// address / target add by default
		o_ctrl.opa_sel = 1'b0;
		o_ctrl.opb_sel = 1'b0;
		o_ctrl.br_un   = 1'b0;
		o_ctrl.bmask   = 3'b000;
		o_ctrl.ld_sel  = LD_W;
		o_ctrl.wb_sel  = WB_ALU;
		case (opcode)
			LOAD: begin
				rd_wr          = 1'b1;
				o_ctrl.opb_sel = 1'b1;
				o_ctrl.wb_sel  = WB_LOAD;
				vld            = 1'b1;
				case (funct3)
					3'b000:  o_ctrl.ld_sel = LD_B;
					3'b001:  o_ctrl.ld_sel = LD_H;
					3'b010:  o_ctrl.ld_sel = LD_W;
					3'b100:  o_ctrl.ld_sel = LD_BU;
					3'b101:  o_ctrl.ld_sel = LD_HU;
					default: vld = 1'b0;	// funct3 3, 6, 7 undefined
				endcase
			end
			OP_IMM: begin
				rd_wr          = 1'b1;
				o_ctrl.opb_sel = 1'b1;
				vld            = (funct3 != 3'b001) | ~f7_30;	// slli needs f7[30] clear
				case (funct3)
					3'b000:  o_ctrl.alu_op = ADD;
					3'b001:  o_ctrl.alu_op = SLL;
					3'b010:  o_ctrl.alu_op = SLT;
					3'b011:  o_ctrl.alu_op = SLTU;
					3'b100:  o_ctrl.alu_op = XOR;
					3'b101: begin
						if (f7_30) o_ctrl.alu_op = SRA;
						else       o_ctrl.alu_op = SRL;
					end
					3'b110:  o_ctrl.alu_op = OR;
					default: o_ctrl.alu_op = AND;
				endcase
			end
			AUIPC: begin
				vld            = 1'b1;
				rd_wr          = 1'b1;
				o_ctrl.imm_sel = IMM_U;
				o_ctrl.opa_sel = 1'b1;	// pc + imm
				o_ctrl.opb_sel = 1'b1;
			end
			STORE: begin
				vld            = (funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b010);
				mem_wr         = 1'b1;
				o_ctrl.imm_sel = IMM_S;
				o_ctrl.opb_sel = 1'b1;
				o_ctrl.bmask   = {funct3 == 3'b010, funct3 == 3'b001, funct3 == 3'b000};
			end
			OP: begin
				rd_wr = 1'b1;
				if (f7_25) begin	// mul group, funct3 0..3 only
					vld = ~f7_30 & ~funct3[2];
					case (funct3[1:0])
						2'b00:   o_ctrl.alu_op = MUL;
						2'b01:   o_ctrl.alu_op = MULH;
						2'b10:   o_ctrl.alu_op = MULHSU;
						default: o_ctrl.alu_op = MULHU;
					endcase
				end else begin
					vld = ~f7_30 | (funct3 == 3'b000) | (funct3 == 3'b101);	// only sub, sra
					case (funct3)
						3'b000: begin
							if (f7_30) o_ctrl.alu_op = SUB;
							else       o_ctrl.alu_op = ADD;
						end
						3'b001:  o_ctrl.alu_op = SLL;
						3'b010:  o_ctrl.alu_op = SLT;
						3'b011:  o_ctrl.alu_op = SLTU;
						3'b100:  o_ctrl.alu_op = XOR;
						3'b101: begin
							if (f7_30) o_ctrl.alu_op = SRA;
							else       o_ctrl.alu_op = SRL;
						end
						3'b110:  o_ctrl.alu_op = OR;
						default: o_ctrl.alu_op = AND;
					endcase
				end
			end
			LUI: begin
				vld            = 1'b1;
				rd_wr          = 1'b1;
				o_ctrl.imm_sel = IMM_U;
				o_ctrl.opb_sel = 1'b1;
				o_ctrl.alu_op  = PASSB;
			end
			BRANCH: begin
				vld            = funct3[2] | ~funct3[1];	// 010, 011 undefined
				o_ctrl.imm_sel = IMM_B;
				o_ctrl.opa_sel = 1'b1;	// target pc + imm
				o_ctrl.opb_sel = 1'b1;
				o_ctrl.br_un   = ~funct3[1];	// beq bne blt bge signed
				case (funct3)
					3'b000:         pc_sel = i_br_equal;
					3'b001:         pc_sel = ~i_br_equal;
					3'b100, 3'b110: pc_sel = i_br_less;
					3'b101, 3'b111: pc_sel = ~i_br_less;
					default:        pc_sel = 1'b0;
				endcase
			end
			JALR: begin
				vld            = (funct3 == 3'b000);
				rd_wr          = 1'b1;
				pc_sel         = vld;	// rs1 + imm
				o_ctrl.opb_sel = 1'b1;
				o_ctrl.wb_sel  = WB_PC4;
			end
			JAL: begin
				vld            = 1'b1;
				rd_wr          = 1'b1;
				pc_sel         = 1'b1;
				o_ctrl.imm_sel = IMM_J;
				o_ctrl.opa_sel = 1'b1;
				o_ctrl.opb_sel = 1'b1;
				o_ctrl.wb_sel  = WB_PC4;
			end
			default: ;	// unknown opcode, vld stays low
		endcase
	end

	assign o_insn_vld      = vld;
	assign o_ctrl.rd_wren  = rd_wr & vld & i_rst_n;	// no writes in reset
	assign o_ctrl.mem_wren = mem_wr & vld & i_rst_n;

	assign pc_plus4 = o_pc + XLEN'(4);
	assign pc_next  = pc_sel ? {i_alu_res[XLEN-1:1], 1'b0} : pc_plus4;	// jalr lsb cleared

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_pc <= RESET_PC;
		end else begin
			o_pc <= pc_next;
		end
	end

endmodule

/* imm_gen.sv */
`timescale 1ns/10ps

module imm_gen (
	input  logic [rv_pkg::XLEN-1:0] i_insn,
	ctrl_if.imm                     i_ctrl,
	output logic [rv_pkg::XLEN-1:0] o_imm
);
	import rv_pkg::*;

	logic sgn;	// insn sign bit

	assign sgn = i_insn[31];

	always_comb begin
		case (i_ctrl.imm_sel)
			IMM_S:   o_imm = {{(XLEN-12){sgn}}, i_insn[31:25], i_insn[11:7]};
			IMM_B:   o_imm = {{(XLEN-12){sgn}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
			IMM_J:   o_imm = {{(XLEN-20){sgn}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
			IMM_U:   o_imm = {i_insn[31:12], 12'b0};	// upper 20, low zeros
			default: o_imm = {{(XLEN-12){sgn}}, i_insn[31:20]};	// I format
		endcase
	end

endmodule

/* reg_file.sv */
`timescale 1ns/10ps

module reg_file (
	input  logic                    i_clk,
	input  logic [4:0]              i_rs1_addr,
	input  logic [4:0]              i_rs2_addr,
	input  logic [4:0]              i_rd_addr,
	input  logic [rv_pkg::XLEN-1:0] i_rd_data,
	ctrl_if.rf                      i_ctrl,
	output logic [rv_pkg::XLEN-1:0] o_rs1_data,
	output logic [rv_pkg::XLEN-1:0] o_rs2_data
);
	import rv_pkg::*;

	logic [XLEN-1:0] regs [32];	// entry 0 never written

	// async read, x0 hardwired
	assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

	always_ff @(posedge i_clk) begin
		if (i_ctrl.rd_wren && (i_rd_addr != 5'd0)) begin
			regs[i_rd_addr] <= i_rd_data;
		end
	end

endmodule

/* exec_unit.sv */
`timescale 1ns/10ps

module exec_unit (
	input  logic [rv_pkg::XLEN-1:0] i_pc,
	input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
	input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
	input  logic [rv_pkg::XLEN-1:0] i_imm,
	ctrl_if.exe                     i_ctrl,
	output logic [rv_pkg::XLEN-1:0] o_alu_res,
	output logic                    o_br_less,
	output logic                    o_br_equal
);
	import rv_pkg::*;

	logic [XLEN-1:0]          opa;
	logic [XLEN-1:0]          opb;
	logic [4:0]               shamt;	// low 5 bits only
	logic                     sign_a;	// mulh, mulhsu
	logic                     sign_b;	// mulh only
	logic signed [XLEN:0]     mul_a;	// 33-bit extended operands
	logic signed [XLEN:0]     mul_b;
	logic signed [2*XLEN+1:0] prod;

	assign opa   = i_ctrl.opa_sel ? i_pc : i_rs1_data;
	assign opb   = i_ctrl.opb_sel ? i_imm : i_rs2_data;
	assign shamt = opb[4:0];

	// one signed 33x33 multiplier covers all four variants
	assign sign_a = (i_ctrl.alu_op == MULH) || (i_ctrl.alu_op == MULHSU);
	assign sign_b = (i_ctrl.alu_op == MULH);
	assign mul_a  = {sign_a & opa[XLEN-1], opa};
	assign mul_b  = {sign_b & opb[XLEN-1], opb};
	assign prod   = mul_a * mul_b;

	always_comb begin
		case (i_ctrl.alu_op)
			SUB:    o_alu_res = opa - opb;
			SLT:    o_alu_res = XLEN'($signed(opa) < $signed(opb));
			SLTU:   o_alu_res = XLEN'(opa < opb);
			XOR:    o_alu_res = opa ^ opb;
			OR:     o_alu_res = opa | opb;
			AND:    o_alu_res = opa & opb;
			SLL:    o_alu_res = opa << shamt;
			SRL:    o_alu_res = opa >> shamt;
			SRA:    o_alu_res = $signed(opa) >>> shamt;
			PASSB:  o_alu_res = opb;	// lui
			MUL:    o_alu_res = prod[XLEN-1:0];
			MULH, MULHSU, MULHU: begin
				o_alu_res = prod[2*XLEN-1:XLEN];	// upper word
			end
			default: o_alu_res = opa + opb;	// add, address, targets
		endcase
	end

	// branch compare always on rs1 / rs2
	assign o_br_equal = (i_rs1_data == i_rs2_data);
	assign o_br_less  = i_ctrl.br_un ? ($signed(i_rs1_data) < $signed(i_rs2_data))
	                                 : (i_rs1_data < i_rs2_data);

endmodule

/* load_store_unit.sv */
`timescale 1ns/10ps

module load_store_unit #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                    i_clk,
	input  logic [rv_pkg::XLEN-1:0] i_addr,
	input  logic [rv_pkg::XLEN-1:0] i_wdata,
	input  logic [rv_pkg::XLEN-1:0] i_pc4,
	input  logic [rv_pkg::XLEN-1:0] i_alu_res,
	ctrl_if.lsu                     i_ctrl,
	output logic [rv_pkg::XLEN-1:0] o_rd_data
);
	import rv_pkg::*;

	localparam int AW = $clog2(DMEM_WORDS);

	logic [XLEN-1:0] mem [DMEM_WORDS];	// word array
	logic [AW-1:0]   widx;	// word index
	logic [1:0]      boff;	// byte offset
	logic [3:0]      be;	// byte enables
	logic [XLEN-1:0] wdata_sh;	// store data in lane
	logic [XLEN-1:0] rword;
	logic [7:0]      ld_byte;
	logic [15:0]     ld_half;
	logic [XLEN-1:0] ld_data;

	assign widx = i_addr[AW+1:2];
	assign boff = i_addr[1:0];

	always_comb begin
		case (i_ctrl.bmask)
			3'b001:  be = 4'b0001 << boff;	// sb
			3'b010:  be = boff[1] ? 4'b1100 : 4'b0011;	// sh
			3'b100:  be = 4'b1111;	// sw
			default: be = 4'b0000;
		endcase
	end

	assign wdata_sh = i_wdata << {boff, 3'b000};

	always_ff @(posedge i_clk) begin
		if (i_ctrl.mem_wren) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i]) mem[widx][8*i +: 8] <= wdata_sh[8*i +: 8];
			end
		end
	end

	assign rword   = mem[widx];	// async read
	assign ld_byte = rword[{boff, 3'b000} +: 8];
	assign ld_half = boff[1] ? rword[31:16] : rword[15:0];

	always_comb begin
		case (i_ctrl.ld_sel)
			LD_B:    ld_data = {{(XLEN-8){ld_byte[7]}}, ld_byte};
			LD_H:    ld_data = {{(XLEN-16){ld_half[15]}}, ld_half};
			LD_BU:   ld_data = {{(XLEN-8){1'b0}}, ld_byte};
			LD_HU:   ld_data = {{(XLEN-16){1'b0}}, ld_half};
			default: ld_data = rword;	// lw
		endcase
	end

	// writeback select
	always_comb begin
		case (i_ctrl.wb_sel)
			WB_PC4:  o_rd_data = i_pc4;	// jal, jalr link
			WB_LOAD: o_rd_data = ld_data;
			default: o_rd_data = i_alu_res;
		endcase
	end

endmodule

/* rv_core.sv */
`timescale 1ns/10ps

module rv_core #(
	parameter logic [rv_pkg::XLEN-1:0] RESET_PC   = '0,
	parameter int                      DMEM_WORDS = 256
) (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic [rv_pkg::XLEN-1:0] i_insn,
	output logic [rv_pkg::XLEN-1:0] o_pc,
	output logic                    o_insn_vld,
	output logic                    o_rd_wren,
	output logic [4:0]              o_rd_addr,
	output logic [rv_pkg::XLEN-1:0] o_rd_data
);
	import rv_pkg::*;

	logic [XLEN-1:0] pc4;	// link value
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] alu_res;	// also mem address, jump target
	logic [XLEN-1:0] rd_data;
	logic            br_less;
	logic            br_equal;

	ctrl_if ctrl ();	// decoded control bundle

	assign pc4 = o_pc + XLEN'(4);

	control_unit #(.RESET_PC(RESET_PC)) ctrl_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_insn(i_insn),
		.i_br_less(br_less), .i_br_equal(br_equal), .i_alu_res(alu_res),
		.o_pc(o_pc), .o_insn_vld(o_insn_vld), .o_ctrl(ctrl)
	);

	imm_gen imm_i (.i_insn(i_insn), .i_ctrl(ctrl), .o_imm(imm));

	reg_file rf_i (
		.i_clk(i_clk), .i_rs1_addr(i_insn[19:15]), .i_rs2_addr(i_insn[24:20]),
		.i_rd_addr(i_insn[11:7]), .i_rd_data(rd_data), .i_ctrl(ctrl),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
	);

	exec_unit exe_i (
		.i_pc(o_pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
		.i_ctrl(ctrl), .o_alu_res(alu_res), .o_br_less(br_less), .o_br_equal(br_equal)
	);

	load_store_unit #(.DMEM_WORDS(DMEM_WORDS)) lsu_i (
		.i_clk(i_clk), .i_addr(alu_res), .i_wdata(rs2_data), .i_pc4(pc4),
		.i_alu_res(alu_res), .i_ctrl(ctrl), .o_rd_data(rd_data)
	);

	assign o_rd_wren = ctrl.rd_wren;	// already gated by vld and reset
	assign o_rd_addr = i_insn[11:7];
	assign o_rd_data = rd_data;

endmodule

/* rv_checker.sv */
`timescale 1ns/10ps

module rv_checker #(
	parameter logic [31:0] RESET_PC = '0
) (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic [31:0] i_insn,
	input  logic [31:0] i_pc,
	input  logic        i_insn_vld,
	input  logic        i_rd_wren,
	input  logic [4:0]  i_rd_addr,
	input  logic [31:0] i_rd_data,
	output int          o_tests,
	output int          o_errors
);
	logic [31:0] regs [32];	// architectural state
	logic [7:0]  mem_b [32];	// bytes 0..31 used
	logic [31:0] pc_m;
	logic        exp_vld;
	logic        exp_wren;
	logic [31:0] exp_data;
	logic [31:0] exp_npc;
	int          sec_err;

	initial begin
		regs[0]  = '0;
		pc_m     = RESET_PC;
		sec_err  = 0;
		o_tests  = 0;
		o_errors = 0;
	end

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] mul_ref(input logic [1:0] f, input logic [31:0] a,
			input logic [31:0] b);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		ea = {(f == 2'd1 || f == 2'd2) ? {32{a[31]}} : 32'b0, a};	// mulh, mulhsu signed a
		eb = {(f == 2'd1) ? {32{b[31]}} : 32'b0, b};
		p = ea * eb;
		return (f == 2'd0) ? p[31:0] : p[63:32];
	endfunction

	// expected writeback value of one instruction at pc_m
	function automatic logic [31:0] model_step(input logic [31:0] insn, output logic vld,
			output logic wren, output logic [31:0] npc);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ii;
		logic [31:0] ib;
		logic [31:0] ij;
		logic [31:0] ad;
		logic [31:0] w;
		logic        taken;
		f3 = insn[14:12];
		f7 = insn[31:25];
		a  = regs[insn[19:15]];
		b  = regs[insn[24:20]];
		ii = {{20{insn[31]}}, insn[31:20]};
		ib = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
		ij = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
		ad = a + ii;
		w  = {mem_b[5'(ad[4:0] + 5'd3)], mem_b[5'(ad[4:0] + 5'd2)],
		      mem_b[5'(ad[4:0] + 5'd1)], mem_b[ad[4:0]]};	// little endian
		vld = 1'b0;
		npc = pc_m + 32'd4;
		case (insn[6:0])
			7'd55:  vld = 1'b1;
			7'd23:  vld = 1'b1;
			7'd111: vld = 1'b1;
			7'd103: vld = (f3 == 3'd0);
			7'd99:  vld = (f3 != 3'd2) && (f3 != 3'd3);
			7'd3:   vld = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
			7'd35:  vld = (f3 < 3'd3);
			7'd19:  vld = (f3 == 3'd1) ? (f7 == 7'h00)
			            : (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
			7'd51:  vld = (f7 == 7'h00) || (f7 == 7'h01 && !f3[2])
			            || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			default: vld = 1'b0;
		endcase
		wren = vld && (insn[6:0] != 7'd99) && (insn[6:0] != 7'd35);
		if (!vld) return '0;
		case (insn[6:0])
			7'd55:  return {insn[31:12], 12'b0};
			7'd23:  return pc_m + {insn[31:12], 12'b0};
			7'd111: begin
				npc = pc_m + ij;
				return pc_m + 32'd4;
			end
			7'd103: begin
				npc = ad & ~32'd1;
				return pc_m + 32'd4;
			end
			7'd99: begin
				case (f3)
					3'd0:    taken = (a == b);
					3'd1:    taken = (a != b);
					3'd4:    taken = $signed(a) < $signed(b);
					3'd5:    taken = $signed(a) >= $signed(b);
					3'd6:    taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken) npc = pc_m + ib;
				return '0;
			end
			7'd3: begin
				case (f3)
					3'd0:    return {{24{w[7]}}, w[7:0]};
					3'd1:    return {{16{w[15]}}, w[15:0]};
					3'd4:    return {24'b0, w[7:0]};
					3'd5:    return {16'b0, w[15:0]};
					default: return w;
				endcase
			end
			7'd19:  return alu_ref(f3, (f3 == 3'd5) && insn[30], a, ii);
			7'd51:  return (f7 == 7'h01) ? mul_ref(f3[1:0], a, b) : alu_ref(f3, insn[30], a, b);
			default: return '0;
		endcase
	endfunction

	task automatic store_ref(input logic [31:0] insn);
		logic [31:0] ad;
		logic [31:0] d;
		ad = regs[insn[19:15]] + {{20{insn[31]}}, insn[31:25], insn[11:7]};
		d  = regs[insn[24:20]];
		for (int k = 0; k < (1 << insn[13:12]); k++) begin
			mem_b[5'(ad[4:0] + 5'(k))] = d[8*k +: 8];
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s: expected %h, got %h at pc %h", name, exp, act, pc_m);
			sec_err++;
			o_errors++;
		end
	endtask

	// outputs settle between edges
	always @(negedge i_clk) begin
		if (!i_rst_n) begin
			pc_m = RESET_PC;
			check_val("o_pc", RESET_PC, i_pc);
			check_val("o_rd_wren", 32'd0, {31'b0, i_rd_wren});
		end else begin
			exp_data = model_step(i_insn, exp_vld, exp_wren, exp_npc);
			check_val("o_pc", pc_m, i_pc);
			check_val("o_insn_vld", {31'b0, exp_vld}, {31'b0, i_insn_vld});
			check_val("o_rd_wren", {31'b0, exp_wren}, {31'b0, i_rd_wren});
			if (exp_wren) begin
				check_val("o_rd_addr", {27'b0, i_insn[11:7]}, {27'b0, i_rd_addr});
				check_val("o_rd_data", exp_data, i_rd_data);
				if (i_insn[11:7] != 5'd0) regs[i_insn[11:7]] = exp_data;
			end
			if (exp_vld && i_insn[6:0] == 7'd35) store_ref(i_insn);
			if (i_insn[19:0] == 20'h00013 && i_insn[31:20] != 12'd0) begin	// section marker
				if (sec_err == 0) $display("test %0d done, no errors", i_insn[31:20]);
				else $display("test %0d done, %0d errors", i_insn[31:20], sec_err);
				sec_err = 0;
				o_tests++;
			end
			pc_m = exp_npc;
		end
	end

endmodule

/* tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;
	localparam logic [31:0] SEED = 32'haa03_889c;
	localparam int N_TESTS = 7;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [31:0] insn;
	logic [31:0] pc;
	logic        insn_vld;
	logic        rd_wren;
	logic [4:0]  rd_addr;
	logic [31:0] rd_data;
	logic [31:0] prog [256];	// instruction memory image
	int          prog_len;
	logic [31:0] lfsr;
	int          tests;
	int          errors;
	int          cycles;
	int          limit;
	logic        timed_out;

	rv_core #(.RESET_PC(32'h0), .DMEM_WORDS(256)) dut_i (
		.i_clk(clk), .i_rst_n(rst_n), .i_insn(insn), .o_pc(pc), .o_insn_vld(insn_vld),
		.o_rd_wren(rd_wren), .o_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

	rv_checker #(.RESET_PC(32'h0)) chk_i (
		.i_clk(clk), .i_rst_n(rst_n), .i_insn(insn), .i_pc(pc), .i_insn_vld(insn_vld),
		.i_rd_wren(rd_wren), .i_rd_addr(rd_addr), .i_rd_data(rd_data),
		.o_tests(tests), .o_errors(errors)
	);

	always #20 clk = ~clk;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};	// one step per bit
		end
	endtask

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
			input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'd35};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
			input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'd99};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'd111};
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic marker(input int k);
		emit(enc_i(12'(k), 5'd0, 3'd0, 5'd0, 7'd19));	// addi x0, x0, k closes test k
	endtask

	task automatic filler();
		logic [31:0] a;
		logic [31:0] r;
		take_bits(12, a);
		take_bits(4, r);
		emit(enc_i(a[11:0], 5'd1, 3'd0, {1'b0, r[3:1], 1'b1}, 7'd19));	// rd never x0
	endtask

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] r;
		logic [6:0]  f7;
		logic [2:0]  f3;
		for (int i = 1; i < 16; i++) begin	// seed x1..x15
			take_bits(20, a);
			take_bits(12, b);
			emit(enc_u(a[19:0], 5'(i), 7'd55));
			emit(enc_i(b[11:0], 5'(i), 3'd0, 5'(i), 7'd19));
		end
		marker(1);
		for (int i = 0; i < 40; i++) begin	// OP incl. mul group
			take_bits(3, a);
			take_bits(2, b);
			take_bits(4, c);
			take_bits(4, d);
			take_bits(4, r);
			f3 = a[2:0];
			f7 = 7'h00;
			if (b[1:0] == 2'd1) begin
				f7 = 7'h01;
				f3 = {1'b0, a[1:0]};
			end else if (b[1:0] == 2'd2 && (f3 == 3'd0 || f3 == 3'd5)) begin
				f7 = 7'h20;
			end
			emit(enc_r(f7, {1'b0, d[3:0]}, {1'b0, c[3:0]}, f3, {1'b0, r[3:0]}, 7'd51));
		end
		marker(2);
		for (int i = 0; i < 30; i++) begin	// OP_IMM
			take_bits(3, a);
			take_bits(12, b);
			take_bits(4, c);
			take_bits(4, r);
			if (a[2:0] == 3'd1) b = {20'b0, 7'h00, b[4:0]};
			if (a[2:0] == 3'd5) b = {20'b0, 1'b0, b[10], 5'b0, b[4:0]};
			if (r[3:0] == 4'd0 && c[3:0] == 4'd0) c = 32'd1;	// keep markers unique
			emit(enc_i(b[11:0], {1'b0, c[3:0]}, a[2:0], {1'b0, r[3:0]}, 7'd19));
		end
		marker(3);
		for (int i = 0; i < 10; i++) begin
			take_bits(20, a);
			take_bits(4, r);
			emit(enc_u(a[19:0], {1'b0, r[3:0]}, 7'd55));
			take_bits(20, a);
			take_bits(4, r);
			emit(enc_u(a[19:0], {1'b0, r[3:0]}, 7'd23));
		end
		marker(4);
		for (int i = 0; i < 8; i++) begin	// fill words 0..7 first
			take_bits(4, d);
			emit(enc_s(12'(4 * i), {1'b0, d[3:0]}, 5'd0, 3'd2));
		end
		for (int i = 0; i < 30; i++) begin
			take_bits(1, a);
			take_bits(4, r);
			take_bits(5, c);
			take_bits(3, b);
			if (a[0]) begin
				f3 = (b[1:0] == 2'd3) ? 3'd2 : {1'b0, b[1:0]};
			end else begin
				case (b[2:0])
					3'd3:    f3 = 3'd4;
					3'd6:    f3 = 3'd5;
					3'd7:    f3 = 3'd2;
					default: f3 = b[2:0];
				endcase
			end
			if (f3[1:0] == 2'd1) c[0] = 1'b0;	// halfword aligned
			if (f3[1:0] == 2'd2) c[1:0] = 2'b00;
			if (a[0]) emit(enc_s({7'b0, c[4:0]}, {1'b0, r[3:0]}, 5'd0, f3));
			else      emit(enc_i({7'b0, c[4:0]}, 5'd0, f3, {1'b0, r[3:0]}, 7'd3));
		end
		marker(5);
		take_bits(19, a);
		emit(enc_u({1'b1, a[18:0]}, 5'd16, 7'd55));	// x16 negative and large unsigned
		for (int i = 0; i < 6; i++) begin	// branches skip one filler when taken
			f3 = (i < 2) ? 3'(i) : 3'(i + 2);	// beq bne blt bge bltu bgeu
			take_bits(4, c);
			emit(enc_b(13'd8, {1'b0, c[3:0]}, {1'b0, c[3:0]}, f3));	// equal operands
			filler();
			emit(enc_b(13'd8, 5'd16, 5'd0, f3));	// zero against negative
			filler();
			emit(enc_b(13'd8, 5'd0, 5'd16, f3));
			filler();
		end
		for (int i = 0; i < 2; i++) begin
			take_bits(4, r);
			emit(enc_j(21'd8, {1'b0, r[3:0]}));
			filler();
			emit(enc_u(20'd0, 5'd16, 7'd23));	// auipc x16, 0
			emit(enc_i(12'd13, 5'd16, 3'd0, 5'd17, 7'd103));	// odd target loses its lsb
			filler();
		end
		marker(6);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5, 7'h0b));	// unknown opcode
		emit(enc_r(7'h20, 5'd2, 5'd1, 3'd1, 5'd6, 7'd51));	// sll with f7[30]
		emit(enc_i(12'd0, 5'd0, 3'd3, 5'd7, 7'd3));	// load funct3 3
		for (int i = 5; i < 8; i++) begin
			emit(enc_r(7'h00, 5'd0, 5'(i), 3'd0, 5'(i + 4), 7'd51));	// read back
		end
		marker(7);
	endtask

	// instruction feed
	always @(posedge clk) begin
		#1;
		if (pc < 32'(prog_len * 4)) insn <= prog[pc[9:2]];
		else                        insn <= 32'h0000_0013;	// nop
	end

	initial begin
		rst_n     = 1'b0;
		insn      = 32'h0000_0013;
		lfsr      = SEED;
		prog_len  = 0;
		cycles    = 0;
		timed_out = 1'b0;
		build_program();
		limit = prog_len * 2 + 20;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		while (pc != 32'(prog_len * 4) && !timed_out) begin
			@(negedge clk);
			cycles++;
			if (cycles >= limit) timed_out = 1'b1;
		end
		#1;	// checker counts settle
		if (timed_out) $display("timeout: program did not finish");
		if (tests != N_TESTS) $display("only %0d of %0d tests completed", tests, N_TESTS);
		$display("tests %0d, errors %0d, cycles %0d", tests, errors, cycles);
		if (timed_out || errors != 0 || tests != N_TESTS) begin
			$display("Test failed");
		end else begin
			$display("Test passed");
		end
		$finish;
	end

endmodule

/* list.f */
rv_pkg.sv
ctrl_if.sv
control_unit.sv
imm_gen.sv
reg_file.sv
exec_unit.sv
load_store_unit.sv
rv_core.sv
rv_checker.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run, then decide by the log
verilator --binary --top-module tb_rv_core -f list.f -o sim_rv_core \
	&& ./obj_dir/sim_rv_core > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
